/* lf_defs.svh */
/*
 * LF front end sizing constants
 * Command length, command FIFO depth, input synchronizer length
 * and the clock divisor loaded at reset
 */

`ifndef LF_DEFS_SVH
`define LF_DEFS_SVH

// ------------------------------------------------------------
// Command link
// ------------------------------------------------------------

// Bits per serial command frame
`define LF_CMD_BITS 16
// Flops in each serial input synchronizer
`define LF_SYNC_STAGES 2

// ------------------------------------------------------------
// Buffering and clocking
// ------------------------------------------------------------

// Entries in the command FIFO, kept a power of two
`define LF_FIFO_DEPTH 4
// Divisor after reset, divided clock period is 2 * (95 + 1) = 192
`define LF_DIV_RESET 95

`endif

/* lf_mode_pkg.sv */
/*
 * LF mode definitions
 * Major mode encoding and the layout of the configuration byte
 */

`default_nettype none

package lf_mode_pkg;

	// Major modes, every encoding not listed here means idle
	typedef enum logic [2:0]
	{
		MODE_READER   = 3'd0,
		MODE_PASSTHRU = 3'd2
	} lf_mode_e;

	// Configuration byte as carried in the low byte of a SET_CONF command
	typedef struct packed
	{
		lf_mode_e   major_mode;
		// Reserved bits, ignored by the controller
		logic [3:0] reserved;
		// Antenna field enable in reader mode
		logic       lf_field;
	} lf_conf_t;

endpackage

`default_nettype wire

/* lf_cmd_pkg.sv */
/*
 * LF command definitions
 * Opcode encoding and the 16-bit command word, whose low byte
 * is either a configuration byte or a clock divisor
 */

`default_nettype none

package lf_cmd_pkg;

	// Command opcodes in the top nibble, other values are rejected
	typedef enum logic [3:0]
	{
		OP_SET_CONF = 4'd1,
		OP_SET_DIV  = 4'd2
	} lf_opcode_e;

	// One command word, decoded by opcode
	typedef union packed
	{
		// Configuration register write
		struct packed
		{
			lf_opcode_e           opcode;
			logic [3:0]           unused;
			lf_mode_pkg::lf_conf_t conf;
		} conf_view;
		// Clock divisor write
		struct packed
		{
			lf_opcode_e opcode;
			logic [3:0] unused;
			logic [7:0] divisor;
		} div_view;
	} lf_cmd_u;

endpackage

`default_nettype wire

/* lf_cmd_rx.sv */
/*
 * Serial command receiver
 * Synchronizes the host link to ncs, shifts in MSB-first frames and
 * offers each complete 16-bit word downstream by a four-phase req/ack
 */

`timescale 1ns/1ns
`default_nettype none

`include "lf_defs.svh"

module lf_cmd_rx
(
	input  wire logic             ncs,
	input  wire logic             rst_n,
	input  wire logic             spck,
	input  wire logic             mosi,
	input  wire logic             spi_cs_n,
	output      logic             rx_req,
	input  wire logic             rx_ack,
	output lf_cmd_pkg::lf_cmd_u   rx_word
);

	localparam int S = `LF_SYNC_STAGES;
	// The counter saturates one past a full frame so long frames stay invalid
	localparam int CNT_W = $clog2(`LF_CMD_BITS + 2);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`LF_CMD_BITS);
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`LF_CMD_BITS + 1);

	// ------------------------------------------------------------
	// Input synchronizers
	// ------------------------------------------------------------

	// Each stage holds {spck, mosi, spi_cs_n}, the last stage only feeds edge detection
	logic [S:0][2:0] sync_q;
	logic spck_rise;
	logic mosi_s;
	logic cs_low;
	logic cs_rise;
	logic [`LF_CMD_BITS-1:0] shift_q;
	logic [CNT_W-1:0] bit_cnt;

	always_ff @(posedge ncs)
	begin
		if (!rst_n)
			// Idle link is clock low, data low, deselected
			sync_q <= {(S + 1){3'b001}};
		else
			sync_q <= {sync_q[S-1:0], {spck, mosi, spi_cs_n}};
	end

	assign spck_rise = sync_q[S-1][2] & ~sync_q[S][2];
	assign mosi_s = sync_q[S-1][1];
	assign cs_low = ~sync_q[S-1][0];
	assign cs_rise = sync_q[S-1][0] & ~sync_q[S][0];

	// ------------------------------------------------------------
	// Frame assembly and handshake
	// ------------------------------------------------------------

	// Bits are counted while selected and the count restarts at every frame end
	always_ff @(posedge ncs)
	begin
		if (!rst_n)
		begin
			bit_cnt <= '0;
			rx_req <= 1'b0;
		end
		else
		begin
			if (cs_rise)
				bit_cnt <= '0;
			else if (cs_low && spck_rise && bit_cnt != CNT_MAX)
				bit_cnt <= bit_cnt + 1'b1;
			// A new request needs a full frame and a closed previous handshake
			if (cs_rise && bit_cnt == CNT_FULL && !rx_req && !rx_ack)
				rx_req <= 1'b1;
			else if (rx_req && rx_ack)
				rx_req <= 1'b0;
		end
	end

	// Shift register and the offered word carry payload only
	always_ff @(posedge ncs)
	begin
		if (cs_low && spck_rise)
			shift_q <= {shift_q[`LF_CMD_BITS-2:0], mosi_s};
		if (cs_rise && bit_cnt == CNT_FULL && !rx_req && !rx_ack)
			rx_word <= shift_q;
	end

	// The offered word must not move until the FIFO has taken it
	assert property (@(posedge ncs) disable iff (!rst_n)
		rx_req |=> (!rx_req || $stable(rx_word)))
		else $error("rx_word changed during an open request");

endmodule

`default_nettype wire

/* lf_cmd_fifo.sv */
/*
 * Command FIFO
 * Circular buffer of command words between the serial receiver and
 * the mode controller, with a four-phase req/ack handshake on each side
 */

`timescale 1ns/1ns
`default_nettype none

`include "lf_defs.svh"

module lf_cmd_fifo
(
	input  wire logic                ncs,
	input  wire logic                rst_n,
	input  wire logic                rx_req,
	output      logic                rx_ack,
	input  wire lf_cmd_pkg::lf_cmd_u rx_word,
	output      logic                cmd_req,
	input  wire logic                cmd_ack,
	output      lf_cmd_pkg::lf_cmd_u cmd_word
);

	localparam int PTR_W = $clog2(`LF_FIFO_DEPTH);
	localparam int CNT_W = $clog2(`LF_FIFO_DEPTH + 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`LF_FIFO_DEPTH);

	lf_cmd_pkg::lf_cmd_u mem [0:`LF_FIFO_DEPTH-1];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	// A word is taken on the first cycle of a request while there is room
	assign push = rx_req && !rx_ack && count != CNT_FULL;
	// The head leaves on the first cycle of the controller's acknowledge
	assign pop = cmd_req && cmd_ack;

	// Head of the queue stays steady for the whole read handshake
	assign cmd_word = mem[rd_ptr];

	always_ff @(posedge ncs)
	begin
		if (push)
			mem[wr_ptr] <= rx_word;
	end

	always_ff @(posedge ncs)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			rx_ack <= 1'b0;
			cmd_req <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + CNT_W'(push) - CNT_W'(pop);
			// Write side ack follows the receiver's request and stays low when full
			if (push)
				rx_ack <= 1'b1;
			else if (!rx_req)
				rx_ack <= 1'b0;
			// Read side offers the head once the last ack has returned low
			if (pop)
				cmd_req <= 1'b0;
			else if (count != '0 && !cmd_ack)
				cmd_req <= 1'b1;
		end
	end

	// A count above the depth would mean a word was written into a full FIFO
	assert property (@(posedge ncs) disable iff (!rst_n)
		count <= CNT_FULL)
		else $error("command written into a full FIFO");

	// A request toward the controller always has a stored word behind it
	assert property (@(posedge ncs) disable iff (!rst_n)
		cmd_req |-> count != '0)
		else $error("command read from an empty FIFO");

endmodule

`default_nettype wire

/* lf_mode_ctrl.sv */
/*
 * LF mode controller
 * Applies configuration and divisor commands, runs the clock divider
 * and drives antenna, A/D clock and sample outputs for the active mode
 */

`timescale 1ns/1ns
`default_nettype none

`include "lf_defs.svh"

module lf_mode_ctrl
(
	input  wire logic                ncs,
	input  wire logic                rst_n,
	input  wire logic                cmd_req,
	output      logic                cmd_ack,
	input  wire lf_cmd_pkg::lf_cmd_u cmd_word,
	input  wire logic [7:0]          adc_d,
	input  wire logic                ssp_dout,
	input  wire logic                cross_lo,
	output      logic                pwr_lo,
	output      logic                pwr_oe1,
	output      logic                adc_clk,
	output      logic [7:0]          sample,
	output      logic                sample_stb,
	output      logic                dbg
);

	lf_mode_pkg::lf_conf_t conf;
	logic [7:0] divisor;
	logic [7:0] div_cnt;
	logic div_clk;
	logic div_wrap;
	logic take_cmd;
	logic load_div;
	logic reader;
	logic div_fall;

	// ------------------------------------------------------------
	// Command decode
	// ------------------------------------------------------------

	// A command is applied on the same edge that raises the acknowledge
	assign take_cmd = cmd_req && !cmd_ack;
	assign load_div = take_cmd && cmd_word.div_view.opcode == lf_cmd_pkg::OP_SET_DIV;

	always_ff @(posedge ncs)
	begin
		if (!rst_n)
		begin
			cmd_ack <= 1'b0;
			conf <= '{major_mode: lf_mode_pkg::MODE_READER, reserved: 4'd0, lf_field: 1'b0};
			divisor <= 8'(`LF_DIV_RESET);
		end
		else
		begin
			cmd_ack <= cmd_req;
			// Unknown opcodes are acknowledged and dropped here
			if (take_cmd && cmd_word.conf_view.opcode == lf_cmd_pkg::OP_SET_CONF)
				conf <= cmd_word.conf_view.conf;
			if (load_div)
				divisor <= cmd_word.div_view.divisor;
		end
	end

	// ------------------------------------------------------------
	// Clock divider
	// ------------------------------------------------------------

	assign div_wrap = div_cnt == divisor;
	// The divided clock is about to go low on this edge
	assign div_fall = div_wrap && div_clk && !load_div;

	always_ff @(posedge ncs)
	begin
		if (!rst_n)
		begin
			div_cnt <= '0;
			div_clk <= 1'b0;
		end
		else if (load_div)
			div_cnt <= '0;
		else if (div_wrap)
		begin
			div_cnt <= '0;
			div_clk <= ~div_clk;
		end
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// ------------------------------------------------------------
	// Mode outputs
	// ------------------------------------------------------------

	assign reader = conf.major_mode == lf_mode_pkg::MODE_READER;

	always_ff @(posedge ncs)
	begin
		if (!rst_n)
		begin
			pwr_lo <= 1'b0;
			pwr_oe1 <= 1'b0;
			adc_clk <= 1'b0;
			sample_stb <= 1'b0;
			dbg <= 1'b0;
		end
		else
		begin
			case (conf.major_mode)
				lf_mode_pkg::MODE_READER:
				begin
					// Field is only driven when the host has switched it on
					pwr_lo <= div_clk & conf.lf_field;
					pwr_oe1 <= 1'b0;
					adc_clk <= div_clk;
					dbg <= 1'b0;
				end
				lf_mode_pkg::MODE_PASSTHRU:
				begin
					pwr_lo <= div_clk;
					pwr_oe1 <= ssp_dout;
					adc_clk <= 1'b0;
					dbg <= cross_lo;
				end
				default:
				begin
					pwr_lo <= 1'b0;
					pwr_oe1 <= 1'b0;
					adc_clk <= 1'b0;
					dbg <= 1'b0;
				end
			endcase
			sample_stb <= reader && div_fall;
		end
	end

	// Sample register loads at the end of each high half-period
	always_ff @(posedge ncs)
	begin
		if (reader && div_fall)
			sample <= adc_d;
	end

	// The acknowledge only rises while the FIFO still holds its request
	assert property (@(posedge ncs) disable iff (!rst_n)
		$rose(cmd_ack) |-> cmd_req)
		else $error("cmd_ack rose without cmd_req");

endmodule

`default_nettype wire

/* lf_frontend_top.sv */
/*
 * LF reader front end
 * Serial command receiver, command FIFO and mode controller
 */

`timescale 1ns/1ns
`default_nettype none

module lf_frontend_top
(
	input  wire logic       ncs,
	input  wire logic       rst_n,
	input  wire logic       spck,
	input  wire logic       mosi,
	input  wire logic       spi_cs_n,
	input  wire logic [7:0] adc_d,
	input  wire logic       ssp_dout,
	input  wire logic       cross_lo,
	output      logic       pwr_lo,
	output      logic       pwr_oe1,
	output      logic       adc_clk,
	output      logic [7:0] sample,
	output      logic       sample_stb,
	output      logic       dbg
);

	// Receiver to FIFO hop
	logic rx_req;
	logic rx_ack;
	lf_cmd_pkg::lf_cmd_u rx_word;
	// FIFO to controller hop
	logic cmd_req;
	logic cmd_ack;
	lf_cmd_pkg::lf_cmd_u cmd_word;

	lf_cmd_rx u_cmd_rx
	(
		.ncs(ncs), .rst_n(rst_n),
		.spck(spck), .mosi(mosi), .spi_cs_n(spi_cs_n),
		.rx_req(rx_req), .rx_ack(rx_ack), .rx_word(rx_word)
	);

	lf_cmd_fifo u_cmd_fifo
	(
		.ncs(ncs), .rst_n(rst_n),
		.rx_req(rx_req), .rx_ack(rx_ack), .rx_word(rx_word),
		.cmd_req(cmd_req), .cmd_ack(cmd_ack), .cmd_word(cmd_word)
	);

	lf_mode_ctrl u_mode_ctrl
	(
		.ncs(ncs), .rst_n(rst_n),
		.cmd_req(cmd_req), .cmd_ack(cmd_ack), .cmd_word(cmd_word),
		.adc_d(adc_d), .ssp_dout(ssp_dout), .cross_lo(cross_lo),
		.pwr_lo(pwr_lo), .pwr_oe1(pwr_oe1), .adc_clk(adc_clk),
		.sample(sample), .sample_stb(sample_stb), .dbg(dbg)
	);

endmodule

`default_nettype wire

/* tb_lf_frontend.sv */
/*
 * Testbench for the LF reader front end
 * Loads commands over the serial link and checks the divider, field
 * control, sample capture, passthrough, command filtering and bursts
 */

`timescale 1ns/1ns
`default_nettype none

`include "lf_defs.svh"

module tb_lf_frontend;

	localparam int CLK_PERIOD = 100;
	// Serial half-period in ncs cycles
	localparam int HALF_BIT = 4;
	// Longest frame sent is one bit over a command plus select setup and hold
	localparam int FRAME_CYCLES = 2 * HALF_BIT * (`LF_CMD_BITS + 1) + 4 * HALF_BIT;
	localparam int N_TESTS = 6;
	localparam int FRAMES_PER_TEST = 3;
	// Each test watches at most about 8 periods of the slowest divided clock
	localparam int WINDOW_CYCLES = 8 * 2 * 256;
	localparam int TIMEOUT_CYCLES =
		2 * N_TESTS * (FRAMES_PER_TEST * FRAME_CYCLES + WINDOW_CYCLES);

	logic ncs;
	logic rst_n;
	logic spck;
	logic mosi;
	logic spi_cs_n;
	logic [7:0] adc_d;
	logic ssp_dout;
	logic cross_lo;
	logic pwr_lo;
	logic pwr_oe1;
	logic adc_clk;
	logic [7:0] sample;
	logic sample_stb;
	logic dbg;

	// Acknowledges seen from the controller and commands expected to reach it
	int ack_count = 0;
	logic ack_prev = 1'b0;
	int acks_sent = 0;
	// Divisor the controller should be running with
	int cur_div = `LF_DIV_RESET;

	lf_frontend_top dut
	(
		.ncs(ncs), .rst_n(rst_n),
		.spck(spck), .mosi(mosi), .spi_cs_n(spi_cs_n),
		.adc_d(adc_d), .ssp_dout(ssp_dout), .cross_lo(cross_lo),
		.pwr_lo(pwr_lo), .pwr_oe1(pwr_oe1), .adc_clk(adc_clk),
		.sample(sample), .sample_stb(sample_stb), .dbg(dbg)
	);

	always #(CLK_PERIOD / 2) ncs = ~ncs;

	// Count rising edges of the controller's acknowledge
	always @(negedge ncs)
	begin
		ack_prev <= dut.cmd_ack;
		if (dut.cmd_ack && !ack_prev)
			ack_count <= ack_count + 1;
	end

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------

	task automatic check(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("MISMATCH %s expected %0h actual %0h", test, expected, actual);
			$display("tests failed");
			$fatal(1, "value check failed in %s", test);
		end
	endtask

	function automatic lf_cmd_pkg::lf_cmd_u div_cmd(input logic [7:0] d);
		lf_cmd_pkg::lf_cmd_u w;
		w.div_view.opcode = lf_cmd_pkg::OP_SET_DIV;
		w.div_view.unused = 4'd0;
		w.div_view.divisor = d;
		return w;
	endfunction

	function automatic lf_cmd_pkg::lf_cmd_u conf_cmd(input logic [2:0] mode,
		input logic field);
		lf_cmd_pkg::lf_cmd_u w;
		w.conf_view.opcode = lf_cmd_pkg::OP_SET_CONF;
		w.conf_view.unused = 4'd0;
		w.conf_view.conf.major_mode = lf_mode_pkg::lf_mode_e'(mode);
		w.conf_view.conf.reserved = 4'd0;
		w.conf_view.conf.lf_field = field;
		return w;
	endfunction

	// Shifts out the low nbits of data MSB first while mosi changes only with spck low
	task automatic send_frame(input logic [31:0] data, input int nbits);
		int i;
		@(posedge ncs);
		spi_cs_n <= 1'b0;
		spck <= 1'b0;
		repeat (HALF_BIT) @(posedge ncs);
		for (i = nbits - 1; i >= 0; i--)
		begin
			mosi <= data[i];
			repeat (HALF_BIT) @(posedge ncs);
			spck <= 1'b1;
			repeat (HALF_BIT) @(posedge ncs);
			spck <= 1'b0;
		end
		repeat (HALF_BIT) @(posedge ncs);
		spi_cs_n <= 1'b1;
		repeat (HALF_BIT) @(posedge ncs);
	endtask

	task automatic wait_acks(input int target);
		while (ack_count < target)
			@(negedge ncs);
	endtask

	// Sends one command and waits until the controller has taken it
	task automatic issue(input lf_cmd_pkg::lf_cmd_u w);
		send_frame(w, `LF_CMD_BITS);
		acks_sent++;
		wait_acks(acks_sent);
	endtask

	task automatic next_adc_rise(output int waited);
		logic prev;
		logic rose;
		waited = 0;
		prev = adc_clk;
		do
		begin
			@(negedge ncs);
			waited++;
			rose = adc_clk && !prev;
			prev = adc_clk;
		end
		while (!rose);
	endtask

	// The first rise may belong to an old divisor, so the second interval is kept
	task automatic measure_period(output int period);
		int skipped;
		next_adc_rise(skipped);
		next_adc_rise(period);
	endtask

	// ------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------

	task automatic divider_period();
		int period;
		int d;
		measure_period(period);
		check("divider_reset", 2 * (`LF_DIV_RESET + 1), period);
		d = 4 + ($urandom % 37);
		issue(div_cmd(8'(d)));
		cur_div = d;
		measure_period(period);
		check("divider_load", 2 * (d + 1), period);
	endtask

	task automatic field_control();
		int i;
		issue(conf_cmd(3'd0, 1'b1));
		@(negedge ncs);
		for (i = 0; i < 4 * (cur_div + 1); i++)
		begin
			@(negedge ncs);
			check("field_on", adc_clk, pwr_lo);
		end
		issue(conf_cmd(3'd0, 1'b0));
		@(negedge ncs);
		for (i = 0; i < 4 * (cur_div + 1); i++)
		begin
			@(negedge ncs);
			check("field_off", 1'b0, pwr_lo);
		end
	endtask

	task automatic sample_capture();
		int strobes;
		logic prev_clk;
		logic rose;
		logic armed;
		logic [7:0] value;
		strobes = 0;
		armed = 1'b0;
		value = 8'd0;
		prev_clk = adc_clk;
		while (strobes < 4)
		begin
			@(negedge ncs);
			if (sample_stb && armed)
			begin
				check("sample", value, sample);
				strobes++;
			end
			rose = adc_clk && !prev_clk;
			prev_clk = adc_clk;
			// A fresh value is held for the whole high half-period that just began
			if (rose)
			begin
				value = 8'($urandom);
				@(posedge ncs);
				adc_d <= value;
				armed = 1'b1;
			end
		end
	endtask

	task automatic rejected_commands();
		lf_cmd_pkg::lf_cmd_u w;
		logic [15:0] bits;
		int period;
		w = div_cmd(8'(cur_div + 7));
		bits = w;
		send_frame(bits, 15);
		// The last 16 bits of this frame form a valid divisor command
		send_frame({1'b0, bits}, 17);
		w.div_view.opcode = lf_cmd_pkg::lf_opcode_e'(4'd7);
		issue(w);
		check("rejected_acks", acks_sent, ack_count);
		measure_period(period);
		check("rejected_div", 2 * (cur_div + 1), period);
	endtask

	task automatic passthru_mode();
		int i;
		logic a;
		logic b;
		logic prev_a;
		logic prev_b;
		prev_a = 1'b0;
		prev_b = 1'b0;
		issue(conf_cmd(3'd2, 1'b0));
		for (i = 0; i < 4 * (cur_div + 1); i++)
		begin
			a = 1'($urandom % 2);
			b = 1'($urandom % 2);
			@(posedge ncs);
			ssp_dout <= a;
			cross_lo <= b;
			@(negedge ncs);
			// Outputs show the inputs driven one cycle earlier
			if (i > 0)
			begin
				check("passthru_oe1", prev_a, pwr_oe1);
				check("passthru_dbg", prev_b, dbg);
				check("passthru_adc_clk", 1'b0, adc_clk);
				check("passthru_stb", 1'b0, sample_stb);
			end
			prev_a = a;
			prev_b = b;
		end
	endtask

	task automatic fifo_burst();
		int d;
		int i;
		int period;
		d = 4 + ($urandom % 37);
		// A divisor equal to the running one would hide a lost command
		if (d == cur_div)
			d = d + 1;
		send_frame(div_cmd(8'(d)), `LF_CMD_BITS);
		send_frame(conf_cmd(3'd7, 1'b0), `LF_CMD_BITS);
		send_frame(conf_cmd(3'd0, 1'b1), `LF_CMD_BITS);
		acks_sent += 3;
		wait_acks(acks_sent);
		cur_div = d;
		measure_period(period);
		check("burst_div", 2 * (d + 1), period);
		for (i = 0; i < 4 * (d + 1); i++)
		begin
			@(negedge ncs);
			check("burst_field", adc_clk, pwr_lo);
		end
	endtask

	// ------------------------------------------------------------
	// Run control
	// ------------------------------------------------------------

	initial
	begin
		ncs = 1'b0;
		rst_n = 1'b0;
		spck = 1'b0;
		mosi = 1'b0;
		spi_cs_n = 1'b1;
		adc_d = 8'd0;
		ssp_dout = 1'b0;
		cross_lo = 1'b0;
		void'($urandom(32'h790e));
		repeat (2) @(posedge ncs);
		rst_n <= 1'b1;
		divider_period();
		field_control();
		sample_capture();
		rejected_commands();
		passthru_mode();
		fifo_burst();
		$display("all tests passed");
		$finish;
	end

	initial
	begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Watchdog timeout, the tests did not finish within %0d cycles",
			TIMEOUT_CYCLES);
		$display("tests failed");
		$fatal(1, "simulation stopped by the watchdog");
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
lf_mode_pkg.sv
lf_cmd_pkg.sv
lf_cmd_rx.sv
lf_cmd_fifo.sv
lf_mode_ctrl.sv
lf_frontend_top.sv
tb_lf_frontend.sv

/* Bender.yml */
package:
  name: lf_frontend

export_include_dirs:
  - .

sources:
  - lf_mode_pkg.sv
  - lf_cmd_pkg.sv
  - lf_cmd_rx.sv
  - lf_cmd_fifo.sv
  - lf_mode_ctrl.sv
  - lf_frontend_top.sv
  - target: simulation
    files:
      - tb_lf_frontend.sv
